//--- fpRegFile.sv
/*
 * 32 x 32-bit floating-point register file, f0 is an ordinary register
 * Two combinational read ports, one write port
 * A read of the register being written returns the new data
 */

`timescale 1ns/100ps

module fpRegFile (
	input  logic        clk,
	input  logic        rst,
	input  logic [4:0]  ra1,
	input  logic [4:0]  ra2,
	input  logic        we,
	input  logic [4:0]  wa,
	input  logic [31:0] wd,
	output logic [31:0] rd1,
	output logic [31:0] rd2
);

	logic [31:0] regs [32];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wa] <= wd;
		end
	end

	// Write-first bypass for the instruction right behind a result
	assign rd1 = (we && wa == ra1) ? wd : regs[ra1];
	assign rd2 = (we && wa == ra2) ? wd : regs[ra2];

endmodule

//--- fpWriteArb.sv
/*
 * Fixed-priority write-back arbiter, the converter always wins
 * A losing misc request is held and reported through miscBlocked
 */

`timescale 1ns/100ps

module fpWriteArb (
	fpWriteIf.arbiter   cvt,
	fpWriteIf.arbiter   misc,
	input  logic        miscFlagStrobe,
	input  logic [4:0]  miscIntFlags,
	output logic        we,
	output logic [4:0]  wa,
	output logic [31:0] wd,
	output logic        miscBlocked,
	output logic [4:0]  fflags,
	output logic        fflagsValid
);

	logic [4:0] writeFlags;

	assign cvt.grant   = cvt.req;
	assign misc.grant  = misc.req && !cvt.req;
	assign miscBlocked = misc.req && cvt.req;

	// Register-file write port
	assign we         = cvt.req || misc.req;
	assign wa         = cvt.req ? cvt.rd : misc.rd;
	assign wd         = cvt.req ? cvt.data : misc.data;
	assign writeFlags = !we ? 5'b0 : (cvt.req ? cvt.flags : misc.flags);

	// A conversion can finish alongside an integer-result op
	assign fflags      = writeFlags | (miscFlagStrobe ? miscIntFlags : 5'b0);
	assign fflagsValid = we || miscFlagStrobe;

endmodule

//--- fpWriteIf.sv
/*
 * One register-file write request from an execution unit
 * The requester holds rd, data and flags stable until grant is seen at a clock edge
 */

`timescale 1ns/100ps

interface fpWriteIf;

	logic        req;
	logic [4:0]  rd;
	logic [31:0] data;
	// fflags bits NV DZ OF UF NX
	logic [4:0]  flags;
	logic        grant;

	modport requester (output req, rd, data, flags, input grant);
	modport arbiter (input req, rd, data, flags, output grant);

endinterface

//--- fpuCvtUnit.sv
/*
 * Serial fcvt.s.w, one normalizing shift per cycle
 * Rounds toward zero only, inexact is the only flag raised
 * A new start is accepted only while busy is low
 */

`timescale 1ns/100ps

module fpuCvtUnit (
	input  logic        clk,
	input  logic        rst,
	input  logic        start,
	input  logic [4:0]  rd,
	input  logic [31:0] srcA,
	output logic        busy,
	fpWriteIf.requester wr
);

	logic                  normQ;
	logic                  reqQ;
	logic                  signQ;
	logic [31:0]           mag;
	logic [31:0]           absVal;
	logic [4:0]            shiftCnt;
	logic [4:0]            rdQ;
	logic                  magZero;
	logic                  done;
	fpuFmtPkg::floatWord_u res;

	// Magnitude of the signed input, -2^31 maps to 32'h80000000
	assign absVal  = srcA[31] ? (~srcA + 32'd1) : srcA;
	assign magZero = mag == '0;
	// Finished once the leading one is at bit 31, or there is none
	assign done    = magZero || mag[31];

	// **************************************************
	// Control
	// **************************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			normQ <= 1'b0;
			reqQ  <= 1'b0;
		end else if (start) begin
			normQ <= 1'b1;
		end else if (normQ && done) begin
			normQ <= 1'b0;
			reqQ  <= 1'b1;
		end else if (wr.grant) begin
			reqQ <= 1'b0;
		end
	end

	// Normalizing shifter and shift counter
	always_ff @(posedge clk) begin
		if (start) begin
			signQ    <= srcA[31];
			mag      <= absVal;
			shiftCnt <= '0;
			rdQ      <= rd;
		end else if (normQ && !done) begin
			mag      <= mag << 1;
			shiftCnt <= shiftCnt + 5'd1;
		end
	end

	// **************************************************
	// Result packing
	// **************************************************
	always_comb begin
		res.raw = '0;
		if (!magZero) begin
			res.fields.sign = signQ;
			// Bias plus 31 for a leading one at bit 31
			res.fields.exp  = 8'(fpuFmtPkg::expBias + 31 - int'(shiftCnt));
			res.fields.frac = mag[30 -: fpuFmtPkg::fracBits];
		end
	end

	assign busy     = normQ | reqQ;
	assign wr.req   = reqQ;
	assign wr.rd    = rdQ;
	assign wr.data  = res.raw;
	// Truncated bits below the fraction give NX
	assign wr.flags = {4'b0, |mag[7:0]};

endmodule

//--- fpuDecode.sv
/*
 * Combinational OP-FP decode with a one-entry scoreboard for the converter
 * Only one conversion may be in flight, a second one stalls
 * Illegal instructions are flagged and dropped, they never stall
 */

`timescale 1ns/100ps

module fpuDecode (
	input  logic                clk,
	input  logic                rst,
	input  logic                instrValid,
	input  logic [31:0]         instr,
	input  logic                cvtBusy,
	input  logic                miscBlocked,
	output logic                illegal,
	output logic                stall,
	output logic                issueMisc,
	output logic                issueCvt,
	output fpuInstrPkg::fpuOp_e op,
	output logic [4:0]          rs1,
	output logic [4:0]          rs2,
	output logic [4:0]          rd
);

	logic       legal;
	logic       isCvt;
	logic       usesRs1;
	logic       usesRs2;
	logic       writesFp;
	logic       cvtHazard;
	logic       pendValid;
	logic [4:0] pendRd;

	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];
	assign rd  = instr[11:7];

	// **************************************************
	// Opcode decode
	// **************************************************
	always_comb begin
		legal = 1'b0;
		op    = fpuInstrPkg::opSgnj;
		if (instr[6:0] == fpuInstrPkg::opFp) begin
			case (instr[31:25])
				fpuInstrPkg::f7Sgnj: begin
					legal = instr[14:12] <= 3'd2;
					op = (instr[14:12] == 3'd0) ? fpuInstrPkg::opSgnj :
						(instr[14:12] == 3'd1) ? fpuInstrPkg::opSgnjn : fpuInstrPkg::opSgnjx;
				end
				fpuInstrPkg::f7MinMax: begin
					legal = instr[14:12] <= 3'd1;
					op = instr[12] ? fpuInstrPkg::opMax : fpuInstrPkg::opMin;
				end
				fpuInstrPkg::f7Cmp: begin
					// funct3 2 is feq, 1 is flt, 0 is fle
					legal = instr[14:12] <= 3'd2;
					op = (instr[14:12] == 3'd2) ? fpuInstrPkg::opEq :
						(instr[14:12] == 3'd1) ? fpuInstrPkg::opLt : fpuInstrPkg::opLe;
				end
				fpuInstrPkg::f7ClassMvXW: begin
					legal = (rs2 == 5'd0) && (instr[14:12] <= 3'd1);
					op = instr[12] ? fpuInstrPkg::opClass : fpuInstrPkg::opMvXW;
				end
				fpuInstrPkg::f7CvtSW: begin
					// Signed source only, rs2 = 1 would be fcvt.s.wu
					legal = rs2 == 5'd0;
					op = fpuInstrPkg::opCvtSW;
				end
				fpuInstrPkg::f7MvWX: begin
					legal = (rs2 == 5'd0) && (instr[14:12] == 3'd0);
					op = fpuInstrPkg::opMvWX;
				end
				default: legal = 1'b0;
			endcase
		end
	end

	// Register usage of the decoded op
	assign isCvt    = op == fpuInstrPkg::opCvtSW;
	assign usesRs1  = !(op inside {fpuInstrPkg::opMvWX, fpuInstrPkg::opCvtSW});
	assign usesRs2  = op inside {fpuInstrPkg::opSgnj, fpuInstrPkg::opSgnjn, fpuInstrPkg::opSgnjx,
		fpuInstrPkg::opMin, fpuInstrPkg::opMax, fpuInstrPkg::opEq, fpuInstrPkg::opLt,
		fpuInstrPkg::opLe};
	assign writesFp = op inside {fpuInstrPkg::opSgnj, fpuInstrPkg::opSgnjn, fpuInstrPkg::opSgnjx,
		fpuInstrPkg::opMin, fpuInstrPkg::opMax, fpuInstrPkg::opMvWX, fpuInstrPkg::opCvtSW};

	// **************************************************
	// Scoreboard and stall
	// **************************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			pendValid <= 1'b0;
		end else if (issueCvt) begin
			pendValid <= 1'b1;
		end else if (!cvtBusy) begin
			// Drops once the converter has written back
			pendValid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (issueCvt) begin
			pendRd <= rd;
		end
	end

	// One converter only, and no reads or writes of its pending target
	assign cvtHazard = cvtBusy && (isCvt || (pendValid && ((usesRs1 && rs1 == pendRd) ||
		(usesRs2 && rs2 == pendRd) || (writesFp && rd == pendRd))));

	assign stall     = miscBlocked || (instrValid && legal && cvtHazard);
	assign illegal   = instrValid && !legal;
	assign issueMisc = instrValid && legal && !stall && !isCvt;
	assign issueCvt  = instrValid && legal && !stall && isCvt;

endmodule

//--- fpuFmtPkg.sv
/*
 * Single-precision IEEE 754 format constants and views of a float word
 * Only binary32 is described, double precision is not supported
 * Class positions follow the RISC-V fclass bit order
 */

package fpuFmtPkg;

	// Field widths and bias
	localparam int expBits  = 8;
	localparam int fracBits = 23;
	localparam int expBias  = 127;

	// Quiet NaN returned when both min/max operands are NaN
	localparam logic [31:0] canonNaN = 32'h7fc00000;

	typedef struct packed {
		logic                sign;
		logic [expBits-1:0]  exp;
		logic [fracBits-1:0] frac;
	} floatFields_s;

	// Same word, seen as IEEE fields or as plain bits
	typedef union packed {
		logic [31:0]  raw;
		floatFields_s fields;
	} floatWord_u;

	// fclass result bit positions
	localparam int classNegInf  = 0;
	localparam int classNegNorm = 1;
	localparam int classNegSub  = 2;
	localparam int classNegZero = 3;
	localparam int classPosZero = 4;
	localparam int classPosSub  = 5;
	localparam int classPosNorm = 6;
	localparam int classPosInf  = 7;
	localparam int classSNaN    = 8;
	localparam int classQNaN    = 9;

endpackage

//--- fpuInstrPkg.sv
/*
 * OP-FP encodings for the single-precision subset of the RISC-V F extension
 * The fmt field (funct7[1:0]) must be 00, other formats decode as illegal
 * fcvt.s.w is the only conversion, the rm field is ignored
 */

package fpuInstrPkg;

	// Major opcode
	localparam logic [6:0] opFp = 7'b1010011;

	// funct7 groups, fmt = S
	localparam logic [6:0] f7Sgnj      = 7'b0010000;
	localparam logic [6:0] f7MinMax    = 7'b0010100;
	localparam logic [6:0] f7Cmp       = 7'b1010000;
	localparam logic [6:0] f7ClassMvXW = 7'b1110000;
	localparam logic [6:0] f7CvtSW     = 7'b1101000;
	localparam logic [6:0] f7MvWX      = 7'b1111000;

	// Internal operation code carried from decode to the units
	typedef enum logic [3:0] {
		opSgnj,
		opSgnjn,
		opSgnjx,
		opMin,
		opMax,
		opEq,
		opLt,
		opLe,
		opClass,
		opMvXW,
		opMvWX,
		opCvtSW
	} fpuOp_e;

endpackage

//--- fpuLite.f
fpuFmtPkg.sv
fpuInstrPkg.sv
fpWriteIf.sv
fpuDecode.sv
fpRegFile.sv
fpuMiscUnit.sv
fpuCvtUnit.sv
fpWriteArb.sv
fpuLite.sv
fpuLite_chk.sv
fpuLite_tb.sv

//--- fpuLite.sv
/*
 * Single-precision FPU subset: decode, register file, misc unit, converter
 * An instruction is taken on a rising edge with instrValid high and stall low
 * srcA is the integer operand, sampled with the instruction
 */

`timescale 1ns/100ps

module fpuLite (
	input  logic        clk,
	input  logic        rst,
	input  logic        instrValid,
	input  logic [31:0] instr,
	input  logic [31:0] srcA,
	output logic        stall,
	output logic        illegal,
	output logic [31:0] intRes,
	output logic        intValid,
	output logic [4:0]  fflags,
	output logic        fflagsValid
);

	logic                issueMisc;
	logic                issueCvt;
	fpuInstrPkg::fpuOp_e op;
	logic [4:0]          rs1, rs2, rd;
	logic                cvtBusy;
	logic                miscBlocked;
	logic                we;
	logic [4:0]          wa;
	logic [31:0]         wd;
	logic [31:0]         rd1, rd2;
	logic                miscFlagStrobe;
	logic [4:0]          miscIntFlags;

	// Write requests into the arbiter
	fpWriteIf miscWr ();
	fpWriteIf cvtWr ();

	fpuDecode decode0 (
		.clk, .rst, .instrValid, .instr, .cvtBusy, .miscBlocked,
		.illegal, .stall, .issueMisc, .issueCvt, .op, .rs1, .rs2, .rd
	);

	fpRegFile regFile0 (
		.clk, .rst, .ra1(rs1), .ra2(rs2), .we, .wa, .wd, .rd1, .rd2
	);

	fpuMiscUnit misc0 (
		.clk, .rst, .issue(issueMisc), .op, .rd, .a(rd1), .b(rd2), .srcA,
		.wr(miscWr), .intRes, .intValid, .flagStrobe(miscFlagStrobe), .intFlags(miscIntFlags)
	);

	fpuCvtUnit cvt0 (
		.clk, .rst, .start(issueCvt), .rd, .srcA, .busy(cvtBusy), .wr(cvtWr)
	);

	fpWriteArb arb0 (
		.cvt(cvtWr), .misc(miscWr), .miscFlagStrobe, .miscIntFlags,
		.we, .wa, .wd, .miscBlocked, .fflags, .fflagsValid
	);

endmodule

//--- fpuLite_chk.sv
/*
 * Concurrent checks on write-back arbitration, stall cause and flag output
 * Bound into fpuLite, grants are taken from the two write interfaces
 */

`timescale 1ns/100ps

module fpuLite_chk (
	input logic clk,
	input logic rst,
	input logic cvtGrant,
	input logic miscGrant,
	input logic stall,
	input logic cvtBusy,
	input logic miscBlocked,
	input logic fflagsValid
);

	// Single write port, at most one grant per cycle
	grantOneHot: assert property (@(posedge clk) disable iff (rst) !(cvtGrant && miscGrant))
		else $error("Converter and misc grants high in the same cycle");

	// Stall only comes from the converter scoreboard or a denied misc request
	stallCause: assert property (@(posedge clk) disable iff (rst)
		stall |-> (cvtBusy || miscBlocked))
		else $error("Stall high with converter idle and no blocked misc request");

	// Registers are cleared after the first reset edge
	flagsInReset: assert property (@(posedge clk) (rst && $past(rst)) |-> !fflagsValid)
		else $error("Flag output valid during reset");

endmodule

bind fpuLite fpuLite_chk chk0 (
	.clk, .rst, .cvtGrant(cvtWr.grant), .miscGrant(miscWr.grant),
	.stall, .cvtBusy, .miscBlocked, .fflagsValid
);

//--- fpuLite_tb.sv
/*
 * Table-driven testbench for fpuLite, followed by random fcvt.s.w checks
 * Float results are read back with fmv.x.w, flags come from the fflags port
 * Expects fflagsValid with every write-back and with every integer result
 */

`timescale 1ns/100ps

module fpuLite_tb;

	localparam int waitLimit = 50;

	logic        clk;
	logic        rst;
	logic        instrValid;
	logic [31:0] instr;
	logic [31:0] srcA;
	logic        stall;
	logic        illegal;
	logic [31:0] intRes;
	logic        intValid;
	logic [4:0]  fflags;
	logic        fflagsValid;

	int          checkErrors;
	int          timeoutErrors;
	integer      seed;

	// Flag pulses seen since the last accepted instruction that cleared the log
	logic [4:0]  flagLog [$];

	// Stimulus table, chk bits: 0 check intRes, 1 check flags, 2 expect illegal
	logic [31:0] tInstr [100];
	logic [31:0] tSrc [100];
	logic [31:0] tExpInt [100];
	logic [4:0]  tExpFlags [100];
	logic [2:0]  tChk [100];
	int          rowCount;

	// Loaded into f1..f10 in fclass order, -inf first and quiet NaN last
	logic [31:0] loadVals [10] = '{32'hff800000, 32'hc0400000, 32'h80400000, 32'h80000000,
		32'h00000000, 32'h00000001, 32'h3f800000, 32'h7f800000, 32'h7f800001, 32'h7fc00000};
	logic [31:0] cvtVals [8] = '{32'h00000001, 32'hfffffff9, 32'h00000000, 32'h7fffffff,
		32'h80000000, 32'h00ffffff, 32'h01000001, 32'h12345678};

	fpuLite dut0 (
		.clk, .rst, .instrValid, .instr, .srcA,
		.stall, .illegal, .intRes, .intValid, .fflags, .fflagsValid
	);

	always #2 clk = ~clk;

	always @(negedge clk) begin
		if (!rst && fflagsValid) begin
			flagLog.push_back(fflags);
		end
	end

	// **************************************************
	// Encoding helpers and reference model
	// **************************************************
	function automatic logic [31:0] rType(input logic [6:0] f7, input int rs2, input int rs1,
		input int f3, input int rd);
		return {f7, 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), fpuInstrPkg::opFp};
	endfunction

	function automatic logic [31:0] mvwx(input int rd);
		return rType(fpuInstrPkg::f7MvWX, 0, 0, 0, rd);
	endfunction

	function automatic logic [31:0] mvxw(input int rs1);
		return rType(fpuInstrPkg::f7ClassMvXW, 0, rs1, 0, 0);
	endfunction

	function automatic logic [31:0] cvtsw(input int rd);
		return rType(fpuInstrPkg::f7CvtSW, 0, 0, 0, rd);
	endfunction

	// Round toward zero int to float, returns {flags, word}
	function automatic logic [36:0] cvtModel(input logic [31:0] v);
		logic [31:0] mag;
		logic [22:0] frac;
		logic        nx;
		int          lead;
		if (v == 32'h0) begin
			return 37'h0;
		end
		mag = v[31] ? (32'h0 - v) : v;
		lead = 31;
		while (!mag[lead]) begin
			lead--;
		end
		if (lead > 23) begin
			frac = 23'(mag >> (lead - 23));
			nx = (mag & ((32'h1 << (lead - 23)) - 32'h1)) != 32'h0;
		end else begin
			frac = 23'(mag << (23 - lead));
			nx = 1'b0;
		end
		return {4'b0, nx, v[31], 8'(127 + lead), frac};
	endfunction

	task automatic addRow(input logic [31:0] ins, input logic [31:0] src,
		input logic [31:0] expInt, input logic [4:0] expFlags, input logic [2:0] chk);
		tInstr[rowCount] = ins;
		tSrc[rowCount] = src;
		tExpInt[rowCount] = expInt;
		tExpFlags[rowCount] = expFlags;
		tChk[rowCount] = chk;
		rowCount++;
	endtask

	// Float-result op, then its destination read back
	task automatic addOpRead(input logic [31:0] ins, input logic [31:0] src, input int rd,
		input logic [31:0] expVal, input logic [4:0] expFlags);
		addRow(ins, src, 32'h0, expFlags, 3'b010);
		addRow(mvxw(rd), 32'h0, expVal, 5'h0, 3'b011);
	endtask

	task automatic buildTable();
		logic [36:0] m;
		rowCount = 0;
		// Moves with a dependent read right behind each
		for (int k = 0; k < 10; k++) begin
			addRow(mvwx(k + 1), loadVals[k], 32'h0, 5'h0, 3'b000);
			addRow(mvxw(k + 1), 32'h0, loadVals[k], 5'h0, 3'b011);
		end
		// Sign injection
		addOpRead(rType(fpuInstrPkg::f7Sgnj, 2, 7, 0, 11), 0, 11, 32'hbf800000, 5'h0);
		addOpRead(rType(fpuInstrPkg::f7Sgnj, 2, 7, 1, 12), 0, 12, 32'h3f800000, 5'h0);
		addOpRead(rType(fpuInstrPkg::f7Sgnj, 2, 2, 2, 13), 0, 13, 32'h40400000, 5'h0);
		addOpRead(rType(fpuInstrPkg::f7Sgnj, 4, 10, 0, 14), 0, 14, 32'hffc00000, 5'h0);
		addOpRead(rType(fpuInstrPkg::f7Sgnj, 5, 5, 1, 15), 0, 15, 32'h80000000, 5'h0);
		addOpRead(rType(fpuInstrPkg::f7Sgnj, 1, 4, 2, 16), 0, 16, 32'h00000000, 5'h0);
		// Compares, funct3 2 feq, 1 flt, 0 fle
		addRow(rType(fpuInstrPkg::f7Cmp, 5, 4, 2, 0), 0, 32'h1, 5'h00, 3'b011);
		addRow(rType(fpuInstrPkg::f7Cmp, 5, 4, 1, 0), 0, 32'h0, 5'h00, 3'b011);
		addRow(rType(fpuInstrPkg::f7Cmp, 4, 5, 0, 0), 0, 32'h1, 5'h00, 3'b011);
		addRow(rType(fpuInstrPkg::f7Cmp, 7, 10, 2, 0), 0, 32'h0, 5'h00, 3'b011);
		addRow(rType(fpuInstrPkg::f7Cmp, 7, 10, 1, 0), 0, 32'h0, 5'h10, 3'b011);
		addRow(rType(fpuInstrPkg::f7Cmp, 9, 7, 0, 0), 0, 32'h0, 5'h10, 3'b011);
		addRow(rType(fpuInstrPkg::f7Cmp, 9, 9, 2, 0), 0, 32'h0, 5'h10, 3'b011);
		addRow(rType(fpuInstrPkg::f7Cmp, 7, 2, 1, 0), 0, 32'h1, 5'h00, 3'b011);
		// Min and max, -0 below +0, NaN operands
		addOpRead(rType(fpuInstrPkg::f7MinMax, 4, 5, 0, 17), 0, 17, 32'h80000000, 5'h00);
		addOpRead(rType(fpuInstrPkg::f7MinMax, 5, 4, 1, 18), 0, 18, 32'h00000000, 5'h00);
		addOpRead(rType(fpuInstrPkg::f7MinMax, 7, 10, 0, 19), 0, 19, 32'h3f800000, 5'h00);
		addOpRead(rType(fpuInstrPkg::f7MinMax, 9, 2, 1, 20), 0, 20, 32'hc0400000, 5'h10);
		addOpRead(rType(fpuInstrPkg::f7MinMax, 10, 9, 0, 21), 0, 21, 32'h7fc00000, 5'h10);
		addOpRead(rType(fpuInstrPkg::f7MinMax, 8, 1, 1, 22), 0, 22, 32'h7f800000, 5'h00);
		// fclass of f(k+1) sets bit k
		for (int k = 0; k < 10; k++) begin
			addRow(rType(fpuInstrPkg::f7ClassMvXW, 0, k + 1, 1, 0), 0, 32'h1 << k, 5'h0, 3'b011);
		end
		for (int k = 0; k < 8; k++) begin
			m = cvtModel(cvtVals[k]);
			addOpRead(cvtsw(23), cvtVals[k], 23, m[31:0], m[36:32]);
		end
		// Bad funct3, double format, unsigned convert, all aimed at f7
		addRow(rType(fpuInstrPkg::f7Sgnj, 2, 2, 3, 7), 0, 32'h0, 5'h0, 3'b100);
		addRow(rType(7'b0010101, 2, 2, 0, 7), 0, 32'h0, 5'h0, 3'b100);
		addRow(rType(fpuInstrPkg::f7CvtSW, 1, 0, 0, 7), 32'h5, 32'h0, 5'h0, 3'b100);
		addRow(mvxw(7), 32'h0, 32'h3f800000, 5'h0, 3'b001);
	endtask

	// **************************************************
	// Drive, wait and compare
	// **************************************************
	task automatic checkValue(input string name, input int row, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			checkErrors++;
			$display("CHECK FAILED row %0d %s: got %h, expected %h", row, name, got, exp);
		end
	endtask

	// Called 1 ns after a rising edge, returns 1 ns after the accepting edge
	task automatic issueInstr(input logic [31:0] ins, input logic [31:0] src, input bit clearLog,
		output int stallCycles, output logic sawIllegal);
		int cnt;
		cnt = 0;
		instrValid = 1'b1;
		instr = ins;
		srcA = src;
		@(negedge clk);
		while (stall && cnt < waitLimit) begin
			@(negedge clk);
			cnt++;
		end
		stallCycles = cnt;
		sawIllegal = illegal;
		assert (!stall) else begin
			timeoutErrors++;
			$display("Timeout: stall stayed high for %0d cycles", waitLimit);
		end
		@(posedge clk);
		#1;
		instrValid = 1'b0;
		if (clearLog) begin
			flagLog.delete();
		end
	endtask

	// Returns at a falling edge with intValid high, or after the timeout
	task automatic waitIntValid(output bit ok);
		int cnt;
		cnt = 0;
		@(negedge clk);
		while (!intValid && cnt < waitLimit) begin
			@(negedge clk);
			cnt++;
		end
		ok = intValid;
		assert (ok) else begin
			timeoutErrors++;
			$display("Timeout: no integer result within %0d cycles", waitLimit);
		end
	endtask

	// Log is filled at falling edges, so it is polled at rising ones
	task automatic waitFlagPulse(output bit ok);
		int cnt;
		cnt = 0;
		@(posedge clk);
		while (flagLog.size() == 0 && cnt < waitLimit) begin
			@(posedge clk);
			cnt++;
		end
		ok = flagLog.size() != 0;
		assert (ok) else begin
			timeoutErrors++;
			$display("Timeout: no flag output within %0d cycles", waitLimit);
		end
		#1;
	endtask

	// **************************************************
	// Main sequence
	// **************************************************
	initial begin
		int          stallCycles;
		logic        sawIll;
		bit          ok;
		logic [31:0] value;
		logic [36:0] model;
		clk = 1'b0;
		rst = 1'b1;
		instrValid = 1'b0;
		instr = 32'h0;
		srcA = 32'h0;
		seed = 32'h145c_0aad;
		checkErrors = 0;
		timeoutErrors = 0;
		buildTable();
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;

		for (int i = 0; i < rowCount; i++) begin
			issueInstr(tInstr[i], tSrc[i], 1'b1, stallCycles, sawIll);
			checkValue("illegal", i, 32'(sawIll), 32'(tChk[i][2]));
			if (tChk[i][0]) begin
				waitIntValid(ok);
				if (ok) begin
					checkValue("intRes", i, intRes, tExpInt[i]);
					// Integer results carry their flags on the same cycle
					checkValue("fflagsValid", i, 32'(fflagsValid), 32'h1);
					if (tChk[i][1]) begin
						checkValue("fflags", i, 32'(fflags), 32'(tExpFlags[i]));
					end
				end
				@(posedge clk);
				#1;
			end else if (tChk[i][1]) begin
				waitFlagPulse(ok);
				if (ok) begin
					checkValue("fflags", i, 32'(flagLog[0]), 32'(tExpFlags[i]));
				end
			end
		end

		// Random conversions, each read back by a dependent fmv.x.w
		for (int n = 0; n < 40; n++) begin
			value = $random(seed);
			model = cvtModel(value);
			issueInstr(cvtsw(24), value, 1'b1, stallCycles, sawIll);
			issueInstr(mvxw(24), 32'h0, 1'b0, stallCycles, sawIll);
			assert (stallCycles > 0) else begin
				checkErrors++;
				$display("Read of conversion %0d target was not stalled", n);
			end
			// Write-back pulse is logged before the dependent read is accepted
			assert (flagLog.size() == 1) else begin
				checkErrors++;
				$display("Conversion %0d gave %0d flag outputs instead of one", n,
					flagLog.size());
			end
			if (flagLog.size() > 0) begin
				checkValue("random cvt fflags", n, 32'(flagLog[0]), 32'(model[36:32]));
			end
			waitIntValid(ok);
			if (ok) begin
				checkValue("random cvt intRes", n, intRes, model[31:0]);
				checkValue("random fflagsValid", n, 32'(fflagsValid), 32'h1);
			end
			@(posedge clk);
			#1;
		end

		$display("Errors: %0d check, %0d timeout", checkErrors, timeoutErrors);
		if (checkErrors == 0 && timeoutErrors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

//--- fpuMiscUnit.sv
/*
 * One-cycle unit for sign injection, min/max, compare, classify and moves
 * Float results go out as a write request, integer results as a one-cycle strobe
 * Subnormals are handled as ordinary values, nothing is flushed to zero
 */

`timescale 1ns/100ps

module fpuMiscUnit (
	input  logic                clk,
	input  logic                rst,
	input  logic                issue,
	input  fpuInstrPkg::fpuOp_e op,
	input  logic [4:0]          rd,
	input  logic [31:0]         a,
	input  logic [31:0]         b,
	input  logic [31:0]         srcA,
	fpWriteIf.requester         wr,
	output logic [31:0]         intRes,
	output logic                intValid,
	output logic                flagStrobe,
	output logic [4:0]          intFlags
);

	fpuFmtPkg::floatWord_u x;
	fpuFmtPkg::floatWord_u y;
	logic        aNaN, bNaN, aSNaN, bSNaN, aInf, aZero, aSub;
	logic        bothZero, totalLt, cmpLt, cmpEq;
	logic        isIntOp;
	logic        nv;
	logic [9:0]  cls;
	logic [31:0] resNext;
	logic        reqQ, intValidQ;
	logic [31:0] resQ;
	logic [4:0]  flagsQ, rdQ;

	// **************************************************
	// Operand classification
	// **************************************************
	assign x.raw = a;
	assign y.raw = b;

	assign aNaN  = (x.fields.exp == '1) && (x.fields.frac != '0);
	assign bNaN  = (y.fields.exp == '1) && (y.fields.frac != '0);
	// Quiet bit is the top fraction bit
	assign aSNaN = aNaN && !x.fields.frac[22];
	assign bSNaN = bNaN && !y.fields.frac[22];
	assign aInf  = (x.fields.exp == '1) && (x.fields.frac == '0);
	assign aZero = (x.fields.exp == '0) && (x.fields.frac == '0);
	assign aSub  = (x.fields.exp == '0) && (x.fields.frac != '0);
	assign bothZero = (a[30:0] == '0) && (b[30:0] == '0);

	// Sign-magnitude order where -0 sits below +0
	assign totalLt = (x.fields.sign != y.fields.sign) ? x.fields.sign :
		(x.fields.sign ? (a[30:0] > b[30:0]) : (a[30:0] < b[30:0]));
	// IEEE compare treats both zeros as equal
	assign cmpLt = totalLt && !bothZero;
	assign cmpEq = (a == b) || bothZero;

	always_comb begin
		cls = '0;
		if (aNaN) begin
			cls[aSNaN ? fpuFmtPkg::classSNaN : fpuFmtPkg::classQNaN] = 1'b1;
		end else if (aInf) begin
			cls[x.fields.sign ? fpuFmtPkg::classNegInf : fpuFmtPkg::classPosInf] = 1'b1;
		end else if (aZero) begin
			cls[x.fields.sign ? fpuFmtPkg::classNegZero : fpuFmtPkg::classPosZero] = 1'b1;
		end else if (aSub) begin
			cls[x.fields.sign ? fpuFmtPkg::classNegSub : fpuFmtPkg::classPosSub] = 1'b1;
		end else begin
			cls[x.fields.sign ? fpuFmtPkg::classNegNorm : fpuFmtPkg::classPosNorm] = 1'b1;
		end
	end

	// **************************************************
	// Result select
	// **************************************************
	always_comb begin
		resNext = a;
		nv = 1'b0;
		case (op)
			fpuInstrPkg::opSgnj:  resNext = {y.fields.sign, a[30:0]};
			fpuInstrPkg::opSgnjn: resNext = {~y.fields.sign, a[30:0]};
			fpuInstrPkg::opSgnjx: resNext = {x.fields.sign ^ y.fields.sign, a[30:0]};
			fpuInstrPkg::opMin, fpuInstrPkg::opMax: begin
				nv = aSNaN || bSNaN;
				if (aNaN && bNaN) resNext = fpuFmtPkg::canonNaN;
				else if (aNaN) resNext = b;
				else if (bNaN) resNext = a;
				else resNext = (totalLt ^ (op == fpuInstrPkg::opMax)) ? a : b;
			end
			fpuInstrPkg::opEq: begin
				// Quiet compare, only signaling NaNs are invalid
				nv = aSNaN || bSNaN;
				resNext = {31'b0, !aNaN && !bNaN && cmpEq};
			end
			fpuInstrPkg::opLt, fpuInstrPkg::opLe: begin
				nv = aNaN || bNaN;
				resNext = {31'b0, !aNaN && !bNaN && (cmpLt || (op == fpuInstrPkg::opLe && cmpEq))};
			end
			fpuInstrPkg::opClass: resNext = {22'b0, cls};
			fpuInstrPkg::opMvWX:  resNext = srcA;
			default:              resNext = a;
		endcase
	end

	assign isIntOp = op inside {fpuInstrPkg::opEq, fpuInstrPkg::opLt, fpuInstrPkg::opLe,
		fpuInstrPkg::opClass, fpuInstrPkg::opMvXW};

	// **************************************************
	// Output registers
	// **************************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			reqQ      <= 1'b0;
			intValidQ <= 1'b0;
		end else begin
			intValidQ <= issue && isIntOp;
			if (issue && !isIntOp) begin
				reqQ <= 1'b1;
			end else if (wr.grant) begin
				reqQ <= 1'b0;
			end
		end
	end

	// Issue only happens with no request held, so both result kinds share storage
	always_ff @(posedge clk) begin
		if (issue) begin
			resQ   <= resNext;
			flagsQ <= {nv, 4'b0};
			rdQ    <= rd;
		end
	end

	assign wr.req     = reqQ;
	assign wr.rd      = rdQ;
	assign wr.data    = resQ;
	assign wr.flags   = flagsQ;
	assign intRes     = resQ;
	assign intValid   = intValidQ;
	assign flagStrobe = intValidQ;
	assign intFlags   = flagsQ;

endmodule

//--- run.sh
#!/bin/sh
# Compile the fpuLite testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f fpuLite.f --top-module fpuLite_tb -o simv
out=$(./obj_dir/simv)
echo "$out"
echo "$out" | grep -qx "Test OK"
